// File: l15_transducer.f
l15_transducer_pkg.sv
l15_req_if.sv
l15_ret_if.sv
l15_req_arbiter.sv
l15_ret_decoder.sv
l15_ack_ctrl.sv
l15_transducer.sv
tb_l15_transducer.sv

// File: Makefile
# Verilator build and run for the L1.5 transducer testbench

VERILATOR ?= verilator
TOP       ?= tb_l15_transducer
FLIST     ?= l15_transducer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Pass or fail comes from the log, not the simulator exit code
run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_l15_transducer.sv
`timescale 1ns/1ns

module tb_l15_transducer;

  import l15_transducer_pkg::*;

  // Reset, all tests and their worst-case request waits, with margin
  localparam int timeout_cycles = 400;
  localparam int wait_limit = 20;

  logic                        clk_i = 1'b0;
  logic                        rst_n_i;
  logic                        icache_req_v_i;
  logic                        icache_req_ready_o;
  logic [rqtype_width-1:0]     icache_req_rqtype_i;
  logic                        icache_req_nc_i;
  logic [size_width-1:0]       icache_req_size_i;
  logic [paddr_width-1:0]      icache_req_address_i;
  logic [dword_width-1:0]      icache_req_data_i;
  logic [l1rplway_width-1:0]   icache_req_l1rplway_i;
  logic [amo_op_width-1:0]     icache_req_amo_op_i;
  logic                        dcache_req_v_i;
  logic                        dcache_req_ready_o;
  logic [rqtype_width-1:0]     dcache_req_rqtype_i;
  logic                        dcache_req_nc_i;
  logic [size_width-1:0]       dcache_req_size_i;
  logic [paddr_width-1:0]      dcache_req_address_i;
  logic [dword_width-1:0]      dcache_req_data_i;
  logic [l1rplway_width-1:0]   dcache_req_l1rplway_i;
  logic [amo_op_width-1:0]     dcache_req_amo_op_i;
  logic                        icache_ret_v_o;
  logic                        icache_ret_ready_i;
  logic                        dcache_ret_v_o;
  logic                        dcache_ret_ready_i;
  logic [rtntype_width-1:0]    ret_rtntype_o;
  logic                        ret_noncacheable_o;
  logic                        ret_atomic_o;
  logic [dword_width-1:0]      ret_data_0_o;
  logic [dword_width-1:0]      ret_data_1_o;
  logic [dword_width-1:0]      ret_data_2_o;
  logic [dword_width-1:0]      ret_data_3_o;
  logic [inval_addr_width-1:0] ret_inval_address_o;
  logic [l1rplway_width-1:0]   ret_inval_way_o;
  logic                        freeze_o;
  logic                        transducer_l15_val_o;
  logic [rqtype_width-1:0]     transducer_l15_rqtype_o;
  logic                        transducer_l15_nc_o;
  logic [size_width-1:0]       transducer_l15_size_o;
  logic [paddr_width-1:0]      transducer_l15_address_o;
  logic [dword_width-1:0]      transducer_l15_data_o;
  logic [l1rplway_width-1:0]   transducer_l15_l1rplway_o;
  logic [amo_op_width-1:0]     transducer_l15_amo_op_o;
  logic                        l15_transducer_ack_i;
  logic                        l15_transducer_val_i;
  logic [rtntype_width-1:0]    l15_transducer_returntype_i;
  logic                        l15_transducer_noncacheable_i;
  logic                        l15_transducer_atomic_i;
  logic [dword_width-1:0]      l15_transducer_data_0_i;
  logic [dword_width-1:0]      l15_transducer_data_1_i;
  logic [dword_width-1:0]      l15_transducer_data_2_i;
  logic [dword_width-1:0]      l15_transducer_data_3_i;
  logic [inval_addr_width-1:0] l15_transducer_inval_address_15_4_i;
  logic                        l15_transducer_inval_icache_inval_i;
  logic                        l15_transducer_inval_dcache_inval_i;
  logic                        l15_transducer_inval_icache_all_way_i;
  logic                        l15_transducer_inval_dcache_all_way_i;
  logic [l1rplway_width-1:0]   l15_transducer_inval_way_i;
  logic                        transducer_l15_req_ack_o;

  int          err_cnt = 0;
  int          test_cnt = 0;
  int          cycle_cnt = 0;
  logic [31:0] lcg_state = 32'd88;

  l15_transducer DUT (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("Timeout: simulation ran past %0d cycles", timeout_cycles);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Field order rqtype, nc, size, address, data, l1rplway, amo_op
  function automatic logic [req_word_width-1:0] random_req();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    a = lcg_next();
    b = lcg_next();
    c = lcg_next();
    d = lcg_next();
    e = lcg_next();
    return {a[20:16], a[21], a[24:22], b[23:16], c, d, e, a[26:25], a[30:27]};
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic drive_req(input int ch, input logic [req_word_width-1:0] w);
    if (ch == ch_dcache)
    begin
      dcache_req_v_i = 1'b1;
      {dcache_req_rqtype_i, dcache_req_nc_i, dcache_req_size_i, dcache_req_address_i,
       dcache_req_data_i, dcache_req_l1rplway_i, dcache_req_amo_op_i} = w;
    end
    else
    begin
      icache_req_v_i = 1'b1;
      {icache_req_rqtype_i, icache_req_nc_i, icache_req_size_i, icache_req_address_i,
       icache_req_data_i, icache_req_l1rplway_i, icache_req_amo_op_i} = w;
    end
  endtask

  task automatic wait_req_val();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < wait_limit; i++)
    begin
      if (transducer_l15_val_o === 1'b1)
      begin
        seen = 1'b1;
        break;
      end
      @(negedge clk_i);
    end
    assert (seen)
    else
    begin
      $display("No request reached the L1.5 port within %0d cycles", wait_limit);
      err_cnt++;
    end
  endtask

  task automatic check_req_out(input logic [req_word_width-1:0] w);
    logic [rqtype_width-1:0]   rqtype;
    logic                      nc;
    logic [size_width-1:0]     size;
    logic [paddr_width-1:0]    address;
    logic [dword_width-1:0]    data;
    logic [l1rplway_width-1:0] l1rplway;
    logic [amo_op_width-1:0]   amo_op;
    {rqtype, nc, size, address, data, l1rplway, amo_op} = w;
    check_eq("transducer_l15_val_o", 64'(transducer_l15_val_o), 64'd1);
    check_eq("transducer_l15_rqtype_o", 64'(transducer_l15_rqtype_o), 64'(rqtype));
    check_eq("transducer_l15_nc_o", 64'(transducer_l15_nc_o), 64'(nc));
    check_eq("transducer_l15_size_o", 64'(transducer_l15_size_o), 64'(size));
    check_eq("transducer_l15_address_o", 64'(transducer_l15_address_o), 64'(address));
    check_eq("transducer_l15_data_o", transducer_l15_data_o, data);
    check_eq("transducer_l15_l1rplway_o", 64'(transducer_l15_l1rplway_o), 64'(l1rplway));
    check_eq("transducer_l15_amo_op_o", 64'(transducer_l15_amo_op_o), 64'(amo_op));
  endtask

  // One return per call, checked mid low phase
  task automatic drive_return(input logic [rtntype_width-1:0] rtype, input logic inval_d,
                              input logic rdy_i, input logic rdy_d, input logic exp_iv,
                              input logic exp_dv, input logic exp_ack);
    logic [31:0] pay;
    @(negedge clk_i);
    l15_transducer_val_i = 1'b1;
    l15_transducer_returntype_i = rtype;
    l15_transducer_inval_dcache_inval_i = inval_d;
    l15_transducer_data_0_i = {lcg_next(), lcg_next()};
    l15_transducer_data_1_i = {lcg_next(), lcg_next()};
    l15_transducer_data_2_i = {lcg_next(), lcg_next()};
    l15_transducer_data_3_i = {lcg_next(), lcg_next()};
    pay = lcg_next();
    l15_transducer_noncacheable_i = pay[16];
    l15_transducer_atomic_i = pay[17];
    l15_transducer_inval_address_15_4_i = pay[29:18];
    l15_transducer_inval_way_i = pay[31:30];
    icache_ret_ready_i = rdy_i;
    dcache_ret_ready_i = rdy_d;
    #10;
    check_eq("icache_ret_v_o", 64'(icache_ret_v_o), 64'(exp_iv));
    check_eq("dcache_ret_v_o", 64'(dcache_ret_v_o), 64'(exp_dv));
    check_eq("transducer_l15_req_ack_o", 64'(transducer_l15_req_ack_o), 64'(exp_ack));
    check_eq("ret_rtntype_o", 64'(ret_rtntype_o), 64'(rtype));
    check_eq("ret_noncacheable_o", 64'(ret_noncacheable_o), 64'(pay[16]));
    check_eq("ret_atomic_o", 64'(ret_atomic_o), 64'(pay[17]));
    check_eq("ret_data_0_o", ret_data_0_o, l15_transducer_data_0_i);
    check_eq("ret_data_1_o", ret_data_1_o, l15_transducer_data_1_i);
    check_eq("ret_data_2_o", ret_data_2_o, l15_transducer_data_2_i);
    check_eq("ret_data_3_o", ret_data_3_o, l15_transducer_data_3_i);
    check_eq("ret_inval_address_o", 64'(ret_inval_address_o), 64'(pay[29:18]));
    check_eq("ret_inval_way_o", 64'(ret_inval_way_o), 64'(pay[31:30]));
  endtask

  task automatic check_reset_state();
    int errs;
    errs = err_cnt;
    @(negedge clk_i);
    check_eq("freeze_o", 64'(freeze_o), 64'd1);
    check_eq("transducer_l15_val_o", 64'(transducer_l15_val_o), 64'd0);
    check_eq("transducer_l15_req_ack_o", 64'(transducer_l15_req_ack_o), 64'd0);
    check_eq("icache_req_ready_o", 64'(icache_req_ready_o), 64'd1);
    check_eq("dcache_req_ready_o", 64'(dcache_req_ready_o), 64'd1);
    finish_test("reset_state", errs);
  endtask

  task automatic pass_single_request();
    int errs;
    logic [req_word_width-1:0] w;
    errs = err_cnt;
    w = random_req();
    @(negedge clk_i);
    drive_req(ch_icache, w);
    @(negedge clk_i);
    icache_req_v_i = 1'b0;
    wait_req_val();
    check_req_out(w);
    // Held while the L1.5 does not ack
    repeat (3)
    begin
      @(negedge clk_i);
      check_req_out(w);
    end
    l15_transducer_ack_i = 1'b1;
    @(negedge clk_i);
    l15_transducer_ack_i = 1'b0;
    check_eq("transducer_l15_val_o", 64'(transducer_l15_val_o), 64'd0);
    finish_test("single_req", errs);
  endtask

  task automatic check_priority_depth();
    int errs;
    logic [req_word_width-1:0] exp_q[$];
    logic [req_word_width-1:0] iw [2];
    logic [req_word_width-1:0] dw [2];
    errs = err_cnt;
    for (int i = 0; i < 2; i++)
    begin
      iw[i] = random_req();
      dw[i] = random_req();
      @(negedge clk_i);
      drive_req(ch_icache, iw[i]);
      drive_req(ch_dcache, dw[i]);
    end
    @(negedge clk_i);
    icache_req_v_i = 1'b0;
    dcache_req_v_i = 1'b0;
    check_eq("icache_req_ready_o", 64'(icache_req_ready_o), 64'd0);
    check_eq("dcache_req_ready_o", 64'(dcache_req_ready_o), 64'd0);
    exp_q = '{dw[0], dw[1], iw[0], iw[1]};
    while (exp_q.size() > 0)
    begin
      wait_req_val();
      check_req_out(exp_q.pop_front());
      l15_transducer_ack_i = 1'b1;
      @(negedge clk_i);
      l15_transducer_ack_i = 1'b0;
    end
    check_eq("transducer_l15_val_o", 64'(transducer_l15_val_o), 64'd0);
    check_eq("icache_req_ready_o", 64'(icache_req_ready_o), 64'd1);
    check_eq("dcache_req_ready_o", 64'(dcache_req_ready_o), 64'd1);
    finish_test("priority_depth", errs);
  endtask

  task automatic steer_returns();
    int errs;
    errs = err_cnt;
    drive_return(rtn_ifill, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1);
    drive_return(rtn_load, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
    drive_return(rtn_st_ack, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
    drive_return(rtn_atomic, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
    drive_return(rtn_ifill, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
    // One cache busy, so no ack
    drive_return(rtn_load, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
    drive_return(rtn_ifill, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
    @(negedge clk_i);
    l15_transducer_val_i = 1'b0;
    #10;
    check_eq("transducer_l15_req_ack_o", 64'(transducer_l15_req_ack_o), 64'd0);
    check_eq("freeze_o", 64'(freeze_o), 64'd1);
    finish_test("return_steering", errs);
  endtask

  task automatic release_freeze();
    int errs;
    errs = err_cnt;
    drive_return(rtn_int, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    check_eq("freeze_o", 64'(freeze_o), 64'd1);
    @(negedge clk_i);
    l15_transducer_val_i = 1'b0;
    check_eq("freeze_o", 64'(freeze_o), 64'd0);
    drive_return(rtn_load, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
    @(negedge clk_i);
    l15_transducer_val_i = 1'b0;
    check_eq("freeze_o", 64'(freeze_o), 64'd0);
    @(negedge clk_i);
    check_eq("freeze_o", 64'(freeze_o), 64'd0);
    finish_test("wakeup", errs);
  endtask

  initial
  begin
    rst_n_i = 1'b0;
    icache_req_v_i = 1'b0;
    dcache_req_v_i = 1'b0;
    drive_req(ch_icache, '0);
    drive_req(ch_dcache, '0);
    icache_req_v_i = 1'b0;
    dcache_req_v_i = 1'b0;
    icache_ret_ready_i = 1'b0;
    dcache_ret_ready_i = 1'b0;
    l15_transducer_ack_i = 1'b0;
    l15_transducer_val_i = 1'b0;
    l15_transducer_returntype_i = '0;
    l15_transducer_noncacheable_i = 1'b0;
    l15_transducer_atomic_i = 1'b0;
    l15_transducer_data_0_i = '0;
    l15_transducer_data_1_i = '0;
    l15_transducer_data_2_i = '0;
    l15_transducer_data_3_i = '0;
    l15_transducer_inval_address_15_4_i = '0;
    l15_transducer_inval_icache_inval_i = 1'b0;
    l15_transducer_inval_dcache_inval_i = 1'b0;
    l15_transducer_inval_icache_all_way_i = 1'b0;
    l15_transducer_inval_dcache_all_way_i = 1'b0;
    l15_transducer_inval_way_i = '0;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    check_reset_state();
    pass_single_request();
    check_priority_depth();
    steer_returns();
    release_freeze();
    $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// File: l15_transducer.sv
`timescale 1ns/1ns

module l15_transducer
  (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  logic                                         icache_req_v_i,
    output logic                                         icache_req_ready_o,
    input  logic [l15_transducer_pkg::rqtype_width-1:0]   icache_req_rqtype_i,
    input  logic                                         icache_req_nc_i,
    input  logic [l15_transducer_pkg::size_width-1:0]     icache_req_size_i,
    input  logic [l15_transducer_pkg::paddr_width-1:0]    icache_req_address_i,
    input  logic [l15_transducer_pkg::dword_width-1:0]    icache_req_data_i,
    input  logic [l15_transducer_pkg::l1rplway_width-1:0] icache_req_l1rplway_i,
    input  logic [l15_transducer_pkg::amo_op_width-1:0]   icache_req_amo_op_i,
    input  logic                                         dcache_req_v_i,
    output logic                                         dcache_req_ready_o,
    input  logic [l15_transducer_pkg::rqtype_width-1:0]   dcache_req_rqtype_i,
    input  logic                                         dcache_req_nc_i,
    input  logic [l15_transducer_pkg::size_width-1:0]     dcache_req_size_i,
    input  logic [l15_transducer_pkg::paddr_width-1:0]    dcache_req_address_i,
    input  logic [l15_transducer_pkg::dword_width-1:0]    dcache_req_data_i,
    input  logic [l15_transducer_pkg::l1rplway_width-1:0] dcache_req_l1rplway_i,
    input  logic [l15_transducer_pkg::amo_op_width-1:0]   dcache_req_amo_op_i,
    output logic                                         icache_ret_v_o,
    input  logic                                         icache_ret_ready_i,
    output logic                                         dcache_ret_v_o,
    input  logic                                         dcache_ret_ready_i,
    output logic [l15_transducer_pkg::rtntype_width-1:0]  ret_rtntype_o,
    output logic                                         ret_noncacheable_o,
    output logic                                         ret_atomic_o,
    output logic [l15_transducer_pkg::dword_width-1:0]    ret_data_0_o,
    output logic [l15_transducer_pkg::dword_width-1:0]    ret_data_1_o,
    output logic [l15_transducer_pkg::dword_width-1:0]    ret_data_2_o,
    output logic [l15_transducer_pkg::dword_width-1:0]    ret_data_3_o,
    output logic [l15_transducer_pkg::inval_addr_width-1:0] ret_inval_address_o,
    output logic [l15_transducer_pkg::l1rplway_width-1:0] ret_inval_way_o,
    output logic                                         freeze_o,
    output logic                                         transducer_l15_val_o,
    output logic [l15_transducer_pkg::rqtype_width-1:0]   transducer_l15_rqtype_o,
    output logic                                         transducer_l15_nc_o,
    output logic [l15_transducer_pkg::size_width-1:0]     transducer_l15_size_o,
    output logic [l15_transducer_pkg::paddr_width-1:0]    transducer_l15_address_o,
    output logic [l15_transducer_pkg::dword_width-1:0]    transducer_l15_data_o,
    output logic [l15_transducer_pkg::l1rplway_width-1:0] transducer_l15_l1rplway_o,
    output logic [l15_transducer_pkg::amo_op_width-1:0]   transducer_l15_amo_op_o,
    input  logic                                         l15_transducer_ack_i,
    input  logic                                         l15_transducer_val_i,
    input  logic [l15_transducer_pkg::rtntype_width-1:0]  l15_transducer_returntype_i,
    input  logic                                         l15_transducer_noncacheable_i,
    input  logic                                         l15_transducer_atomic_i,
    input  logic [l15_transducer_pkg::dword_width-1:0]    l15_transducer_data_0_i,
    input  logic [l15_transducer_pkg::dword_width-1:0]    l15_transducer_data_1_i,
    input  logic [l15_transducer_pkg::dword_width-1:0]    l15_transducer_data_2_i,
    input  logic [l15_transducer_pkg::dword_width-1:0]    l15_transducer_data_3_i,
    input  logic [l15_transducer_pkg::inval_addr_width-1:0] l15_transducer_inval_address_15_4_i,
    input  logic                                         l15_transducer_inval_icache_inval_i,
    input  logic                                         l15_transducer_inval_dcache_inval_i,
    input  logic                                         l15_transducer_inval_icache_all_way_i,
    input  logic                                         l15_transducer_inval_dcache_all_way_i,
    input  logic [l15_transducer_pkg::l1rplway_width-1:0] l15_transducer_inval_way_i,
    output logic                                         transducer_l15_req_ack_o
  );

  import l15_transducer_pkg::*;

  logic wakeup;

  l15_req_if req_if ();
  l15_ret_if ret_if ();

  l15_req_arbiter u_req_arbiter
  (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .icache_req_v_i        (icache_req_v_i),
    .icache_req_ready_o    (icache_req_ready_o),
    .icache_req_rqtype_i   (icache_req_rqtype_i),
    .icache_req_nc_i       (icache_req_nc_i),
    .icache_req_size_i     (icache_req_size_i),
    .icache_req_address_i  (icache_req_address_i),
    .icache_req_data_i     (icache_req_data_i),
    .icache_req_l1rplway_i (icache_req_l1rplway_i),
    .icache_req_amo_op_i   (icache_req_amo_op_i),
    .dcache_req_v_i        (dcache_req_v_i),
    .dcache_req_ready_o    (dcache_req_ready_o),
    .dcache_req_rqtype_i   (dcache_req_rqtype_i),
    .dcache_req_nc_i       (dcache_req_nc_i),
    .dcache_req_size_i     (dcache_req_size_i),
    .dcache_req_address_i  (dcache_req_address_i),
    .dcache_req_data_i     (dcache_req_data_i),
    .dcache_req_l1rplway_i (dcache_req_l1rplway_i),
    .dcache_req_amo_op_i   (dcache_req_amo_op_i),
    .req_o                 (req_if.src)
  );

  // L1.5 request port
  assign transducer_l15_val_o = req_if.val;
  assign transducer_l15_rqtype_o = req_if.rqtype;
  assign transducer_l15_nc_o = req_if.nc;
  assign transducer_l15_size_o = req_if.size;
  assign transducer_l15_address_o = req_if.address;
  assign transducer_l15_data_o = req_if.data;
  assign transducer_l15_l1rplway_o = req_if.l1rplway;
  assign transducer_l15_amo_op_o = req_if.amo_op;
  assign req_if.ack = l15_transducer_ack_i;

  // Return header into the decoder
  assign ret_if.val = l15_transducer_val_i;
  assign ret_if.rtntype = l15_transducer_returntype_i;
  assign ret_if.inval_icache = l15_transducer_inval_icache_inval_i;
  assign ret_if.inval_dcache = l15_transducer_inval_dcache_inval_i;
  assign ret_if.inval_icache_all = l15_transducer_inval_icache_all_way_i;
  assign ret_if.inval_dcache_all = l15_transducer_inval_dcache_all_way_i;

  l15_ret_decoder u_ret_decoder
  (
    .ret_i      (ret_if.dec),
    .icache_v_o (icache_ret_v_o),
    .dcache_v_o (dcache_ret_v_o),
    .wakeup_o   (wakeup)
  );

  l15_ack_ctrl u_ack_ctrl
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .icache_v_i     (icache_ret_v_o),
    .dcache_v_i     (dcache_ret_v_o),
    .wakeup_i       (wakeup),
    .icache_ready_i (icache_ret_ready_i),
    .dcache_ready_i (dcache_ret_ready_i),
    .req_ack_o      (transducer_l15_req_ack_o),
    .freeze_o       (freeze_o)
  );

  // Same payload to both caches
  assign ret_rtntype_o = l15_transducer_returntype_i;
  assign ret_noncacheable_o = l15_transducer_noncacheable_i;
  assign ret_atomic_o = l15_transducer_atomic_i;
  assign ret_data_0_o = l15_transducer_data_0_i;
  assign ret_data_1_o = l15_transducer_data_1_i;
  assign ret_data_2_o = l15_transducer_data_2_i;
  assign ret_data_3_o = l15_transducer_data_3_i;
  assign ret_inval_address_o = l15_transducer_inval_address_15_4_i;
  assign ret_inval_way_o = l15_transducer_inval_way_i;

endmodule

// File: l15_ack_ctrl.sv
`timescale 1ns/1ns

module l15_ack_ctrl
  (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic icache_v_i,
    input  logic dcache_v_i,
    input  logic wakeup_i,
    input  logic icache_ready_i,
    input  logic dcache_ready_i,
    output logic req_ack_o,
    output logic freeze_o
  );

  import l15_transducer_pkg::*;

  logic both_ready;
  logic freeze_q;

  // Invalidations are enqueued on both sides, so both need room
  assign both_ready = icache_ready_i & dcache_ready_i;

  // Wake-up is acked here since no cache consumes it
  assign req_ack_o = wakeup_i | (both_ready & (icache_v_i | dcache_v_i));

  // Core held frozen until the first interrupt return
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      freeze_q <= 1'b1;
    else if (wakeup_i)
      freeze_q <= 1'b0;
  end

  assign freeze_o = freeze_q;

  a_freeze_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !freeze_o |=> !freeze_o);

endmodule

// File: l15_ret_decoder.sv
`timescale 1ns/1ns

module l15_ret_decoder
  (
    l15_ret_if.dec ret_i,
    output logic   icache_v_o,
    output logic   dcache_v_o,
    output logic   wakeup_o
  );

  import l15_transducer_pkg::*;

  logic icache_type;
  logic dcache_type;
  logic icache_inval;
  logic dcache_inval;

  // Fill returns belong to the instruction side only
  assign icache_type = (ret_i.rtntype == rtn_ifill);

  // Loads, store acks and atomics go to the data side
  assign dcache_type = ret_i.rtntype inside {rtn_load, rtn_st_ack, rtn_atomic};

  // single-line or all-way invalidation
  assign icache_inval = ret_i.inval_icache | ret_i.inval_icache_all;
  assign dcache_inval = ret_i.inval_dcache | ret_i.inval_dcache_all;

  // An invalidation can ride on any return type, so both sides may fire
  assign icache_v_o = ret_i.val & (icache_type | icache_inval);
  assign dcache_v_o = ret_i.val & (dcache_type | dcache_inval);

  assign wakeup_o = ret_i.val & (ret_i.rtntype == rtn_int);

  // Interrupt returns must not carry invalidations
  always_comb
  begin
    a_wakeup_alone: assert final (!(wakeup_o && (icache_v_o || dcache_v_o)))
      else $error("wake-up return also steered to a cache");
  end

endmodule

// File: l15_req_arbiter.sv
`timescale 1ns/1ns

module l15_req_arbiter
  (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  logic                                         icache_req_v_i,
    output logic                                         icache_req_ready_o,
    input  logic [l15_transducer_pkg::rqtype_width-1:0]   icache_req_rqtype_i,
    input  logic                                         icache_req_nc_i,
    input  logic [l15_transducer_pkg::size_width-1:0]     icache_req_size_i,
    input  logic [l15_transducer_pkg::paddr_width-1:0]    icache_req_address_i,
    input  logic [l15_transducer_pkg::dword_width-1:0]    icache_req_data_i,
    input  logic [l15_transducer_pkg::l1rplway_width-1:0] icache_req_l1rplway_i,
    input  logic [l15_transducer_pkg::amo_op_width-1:0]   icache_req_amo_op_i,
    input  logic                                         dcache_req_v_i,
    output logic                                         dcache_req_ready_o,
    input  logic [l15_transducer_pkg::rqtype_width-1:0]   dcache_req_rqtype_i,
    input  logic                                         dcache_req_nc_i,
    input  logic [l15_transducer_pkg::size_width-1:0]     dcache_req_size_i,
    input  logic [l15_transducer_pkg::paddr_width-1:0]    dcache_req_address_i,
    input  logic [l15_transducer_pkg::dword_width-1:0]    dcache_req_data_i,
    input  logic [l15_transducer_pkg::l1rplway_width-1:0] dcache_req_l1rplway_i,
    input  logic [l15_transducer_pkg::amo_op_width-1:0]   dcache_req_amo_op_i,
    l15_req_if.src                                       req_o
  );

  import l15_transducer_pkg::*;

  logic [num_req_ch-1:0]     req_v;
  logic [num_req_ch-1:0]     ready;
  logic [num_req_ch-1:0]     push;
  logic [num_req_ch-1:0]     pop;
  logic [num_req_ch-1:0]     not_empty;
  logic [num_req_ch-1:0]     prio_gnt;
  logic [num_req_ch-1:0]     gnt;
  logic [num_req_ch-1:0]     lock_gnt_q;
  logic                      locked_q;
  logic [req_word_width-1:0] req_word [num_req_ch];
  logic [req_word_width-1:0] head_word [num_req_ch];
  logic [req_word_width-1:0] head;

  assign req_v[ch_icache] = icache_req_v_i;
  assign req_v[ch_dcache] = dcache_req_v_i;
  assign icache_req_ready_o = ready[ch_icache];
  assign dcache_req_ready_o = ready[ch_dcache];

  assign req_word[ch_icache] = {icache_req_rqtype_i, icache_req_nc_i, icache_req_size_i,
                                icache_req_address_i, icache_req_data_i,
                                icache_req_l1rplway_i, icache_req_amo_op_i};
  assign req_word[ch_dcache] = {dcache_req_rqtype_i, dcache_req_nc_i, dcache_req_size_i,
                                dcache_req_address_i, dcache_req_data_i,
                                dcache_req_l1rplway_i, dcache_req_amo_op_i};

  for (genvar i = 0; i < num_req_ch; i++)
  begin : g_queue
    logic [req_word_width-1:0] mem_q [req_fifo_depth];
    logic [req_ptr_width-1:0]  wr_ptr_q;
    logic [req_ptr_width-1:0]  rd_ptr_q;
    logic [req_cnt_width-1:0]  cnt_q;

    assign ready[i] = (cnt_q != req_cnt_width'(req_fifo_depth));
    assign not_empty[i] = (cnt_q != '0);
    assign push[i] = req_v[i] & ready[i];
    assign head_word[i] = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i)
    begin
      if (push[i])
        mem_q[wr_ptr_q] <= req_word[i];
    end

    always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
      begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q <= '0;
      end
      else
      begin
        if (push[i])
          wr_ptr_q <= wr_ptr_q + req_ptr_width'(1);
        if (pop[i])
          rd_ptr_q <= rd_ptr_q + req_ptr_width'(1);
        if (push[i] && !pop[i])
          cnt_q <= cnt_q + req_cnt_width'(1);
        else if (pop[i] && !push[i])
          cnt_q <= cnt_q - req_cnt_width'(1);
      end
    end

    a_no_overfill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cnt_q <= req_cnt_width'(req_fifo_depth));
  end

  // Data cache wins when both queues hold a request
  assign prio_gnt[ch_dcache] = not_empty[ch_dcache];
  assign prio_gnt[ch_icache] = not_empty[ch_icache] & ~not_empty[ch_dcache];

  // An unacked head keeps its grant so the L1.5 sees stable fields
  assign gnt = locked_q ? lock_gnt_q : prio_gnt;
  assign pop = gnt & {num_req_ch{req_o.ack}};

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      locked_q <= 1'b0;
      lock_gnt_q <= '0;
    end
    else
    begin
      locked_q <= req_o.val & ~req_o.ack;
      lock_gnt_q <= gnt;
    end
  end

  always_comb
  begin
    head = '0;
    for (int i = 0; i < num_req_ch; i++)
      if (gnt[i])
        head = head | head_word[i];
  end

  assign req_o.val = |gnt;
  assign {req_o.rqtype, req_o.nc, req_o.size, req_o.address, req_o.data,
          req_o.l1rplway, req_o.amo_op} = head;

  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_o.val && !req_o.ack |=> req_o.val && $stable(head));

endmodule

// File: l15_ret_if.sv
`timescale 1ns/1ns

interface l15_ret_if;

  logic                                        val;
  logic [l15_transducer_pkg::rtntype_width-1:0] rtntype;
  logic                                        inval_icache;
  logic                                        inval_dcache;
  logic                                        inval_icache_all;
  logic                                        inval_dcache_all;

  // Return decoder
  modport dec
  (
    input val, rtntype,
    input inval_icache, inval_dcache,
    input inval_icache_all, inval_dcache_all
  );

  // Driven from the L1.5 return inputs
  modport src
  (
    output val, rtntype,
    output inval_icache, inval_dcache,
    output inval_icache_all, inval_dcache_all
  );

endinterface

// File: l15_req_if.sv
`timescale 1ns/1ns

interface l15_req_if;

  logic                                         val;
  logic                                         ack;
  logic [l15_transducer_pkg::rqtype_width-1:0]   rqtype;
  logic                                         nc;
  logic [l15_transducer_pkg::size_width-1:0]     size;
  logic [l15_transducer_pkg::paddr_width-1:0]    address;
  logic [l15_transducer_pkg::dword_width-1:0]    data;
  logic [l15_transducer_pkg::l1rplway_width-1:0] l1rplway;
  logic [l15_transducer_pkg::amo_op_width-1:0]   amo_op;

  // Arbiter side
  modport src
  (
    output val, rqtype, nc, size, address, data, l1rplway, amo_op,
    input  ack
  );

  // L1.5 port side
  modport dst
  (
    input  val, rqtype, nc, size, address, data, l1rplway, amo_op,
    output ack
  );

endinterface

// File: l15_transducer_pkg.sv
package l15_transducer_pkg;

  // Request field widths toward the L1.5
  localparam int paddr_width = 40;
  localparam int dword_width = 64;
  localparam int rqtype_width = 5;
  localparam int size_width = 3;
  localparam int amo_op_width = 4;
  localparam int l1rplway_width = 2;

  // Return side
  localparam int rtntype_width = 4;
  localparam int inval_addr_width = 12;

  // Request queues
  localparam int req_fifo_depth = 2;
  localparam int req_ptr_width = $clog2(req_fifo_depth);
  localparam int req_cnt_width = $clog2(req_fifo_depth + 1);

  // Packed queue entry of rqtype, nc, size, address, data, l1rplway and amo_op
  localparam int req_word_width = rqtype_width
                                + 1
                                + size_width
                                + paddr_width
                                + dword_width
                                + l1rplway_width
                                + amo_op_width;

  // L1.5 return type codes
  localparam logic [rtntype_width-1:0] rtn_load = 4'd0;
  localparam logic [rtntype_width-1:0] rtn_ifill = 4'd1;
  localparam logic [rtntype_width-1:0] rtn_atomic = 4'd3;
  localparam logic [rtntype_width-1:0] rtn_st_ack = 4'd4;
  localparam logic [rtntype_width-1:0] rtn_int = 4'd7;

  // Cache request channels
  localparam int num_req_ch = 2;
  localparam int ch_icache = 0;
  localparam int ch_dcache = 1;

endpackage
